/* Makefile */
VERILATOR  ?= verilator
TOP        := apple1_tb
RTL_TOP    := apple1_core
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The ROM loads monitor_rom.hex from the working directory
sim: build
	cd hw && ../$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* hw/apple1_core.sv */
`timescale 1ns/10ps

module apple1_core #(
    parameter int clks_per_bit = 217    // 115200 baud at 25 MHz
) (
    input  logic                 clk25,      // 25 MHz master clock
    input  logic                 rst,        // Async reset, active high
    input  apple1_pkg::cpu_bus_t bus,        // CPU request, held between strobes
    input  logic                 uart_rx,
    output logic                 cpu_clken,  // 1 MHz strobe for the CPU
    output logic [7:0]           rdata,
    output logic                 uart_tx,
    output logic                 uart_cts
);
    import apple1_pkg::*;

    logic       ram_we;
    logic       term_sel;
    logic       term_we;
    term_reg_e  term_reg;
    logic [7:0] ram_dout;
    logic [7:0] rom_dout;
    logic [7:0] term_dout;

    ////////////////////////////////////////////////////////////////////////////
    // Clock enable and reset stretch

    cpu_clock_reset u_cpu_clock_reset (
        .clk25    (clk25),
        .rst      (rst),
        .cpu_clken(cpu_clken)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Decode and read mux

    bus_decoder u_bus_decoder (
        .clk25    (clk25),
        .rst      (rst),
        .cpu_clken(cpu_clken),
        .bus      (bus),
        .ram_we   (ram_we),
        .term_sel (term_sel),
        .term_we  (term_we),
        .term_reg (term_reg),
        .ram_dout (ram_dout),
        .rom_dout (rom_dout),
        .term_dout(term_dout),
        .rdata    (rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memories

    ram_8k u_ram_8k (
        .clk25    (clk25),
        .cpu_clken(cpu_clken),
        .addr     (bus.addr[RAM_AW-1:0]),
        .we       (ram_we),
        .wdata    (bus.wdata),
        .rdata    (ram_dout)
    );

    monitor_rom u_monitor_rom (
        .clk25    (clk25),
        .cpu_clken(cpu_clken),
        .addr     (bus.addr[ROM_AW-1:0]),  // Page offset only
        .rdata    (rom_dout)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Serial terminal

    terminal_io #(
        .clks_per_bit(clks_per_bit)
    ) u_terminal_io (
        .clk25   (clk25),
        .rst     (rst),
        .sel     (term_sel),
        .we      (term_we),
        .reg_addr(term_reg),
        .wdata   (bus.wdata),
        .rdata   (term_dout),
        .uart_rx (uart_rx),
        .uart_tx (uart_tx),
        .uart_cts(uart_cts)
    );

endmodule

/* hw/apple1_pkg.sv */
package apple1_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Timing constants

    localparam int CLKEN_DIV  = 25;                     // clk25 cycles per CPU enable
    localparam int RESET_HOLD = 4;                      // Enables masked after reset
    localparam int CLKEN_CW   = $clog2(CLKEN_DIV);      // Divider counter width
    localparam int HOLD_CW    = $clog2(RESET_HOLD + 1); // Hold counter width

    ////////////////////////////////////////////////////////////////////////////
    // Memory map

    localparam int RAM_AW = 13;                         // 8 KiB at 0x0000
    localparam int ROM_AW = 8;                          // 256 bytes at 0xFF00

    localparam logic [15:0] TERM_BASE = 16'hD010;       // KBD, KBDCR, DSP, DSPCR
    localparam logic [15:0] ROM_BASE  = 16'hFF00;       // Monitor page

    localparam logic [7:0] UNMAPPED_DATA = 8'hFF;       // Floating bus value

    ////////////////////////////////////////////////////////////////////////////
    // Types

    // One CPU bus request
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } cpu_bus_t;

    // Decoded target of an address
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_ROM,
        REGION_TERM,
        REGION_NONE
    } region_e;

    // Terminal register offsets, low two address bits
    typedef enum logic [1:0] {
        TERM_KBD   = 2'd0,
        TERM_KBDCR = 2'd1,
        TERM_DSP   = 2'd2,
        TERM_DSPCR = 2'd3
    } term_reg_e;

    // Shared by UART transmitter and receiver
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

/* hw/bus_decoder.sv */
`timescale 1ns/10ps

module bus_decoder (
    input  logic                  clk25,
    input  logic                  rst,
    input  logic                  cpu_clken,  // Strobe
    input  apple1_pkg::cpu_bus_t  bus,
    output logic                  ram_we,
    output logic                  term_sel,   // Strobed terminal access
    output logic                  term_we,
    output apple1_pkg::term_reg_e term_reg,
    input  logic [7:0]            ram_dout,
    input  logic [7:0]            rom_dout,
    input  logic [7:0]            term_dout,
    output logic [7:0]            rdata
);
    import apple1_pkg::*;

    region_e region;    // Decoded from current address
    region_e region_q;  // Region of the last strobed access

    ////////////////////////////////////////////////////////////////////////////
    // Address decode

    always_comb
    begin
        if (bus.addr[15:13] == 3'b000)
            region = REGION_RAM;                        // 0x0000 .. 0x1FFF
        else if (bus.addr[15:8] == ROM_BASE[15:8])
            region = REGION_ROM;                        // 0xFF00 .. 0xFFFF
        else if (bus.addr[15:2] == TERM_BASE[15:2])
            region = REGION_TERM;                       // 0xD010 .. 0xD013
        else
            region = REGION_NONE;
    end

    assign ram_we   = cpu_clken && bus.we && (region == REGION_RAM);
    assign term_sel = cpu_clken && (region == REGION_TERM);
    assign term_we  = term_sel && bus.we;
    assign term_reg = term_reg_e'(bus.addr[1:0]);

    ////////////////////////////////////////////////////////////////////////////
    // Read data path

    // Memories register their data at the same strobe
    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
            region_q <= REGION_NONE;    // Bus reads 0xFF out of reset
        else if (cpu_clken)
            region_q <= region;
    end

    always_comb
    begin
        case (region_q)
            REGION_RAM:  rdata = ram_dout;
            REGION_ROM:  rdata = rom_dout;
            REGION_TERM: rdata = term_dout;
            default:     rdata = UNMAPPED_DATA;
        endcase
    end

endmodule

/* hw/cpu_clock_reset.sv */
`timescale 1ns/10ps

module cpu_clock_reset (
    input  logic clk25,      // 25 MHz master clock
    input  logic rst,        // Async reset, active high
    output logic cpu_clken   // One-cycle CPU enable, 1 MHz
);
    import apple1_pkg::*;

    logic [CLKEN_CW-1:0] div_cnt;   // 0 .. CLKEN_DIV-1
    logic [HOLD_CW-1:0]  hold_cnt;  // Terminal counts seen since reset
    logic                div_tc;    // Divider at terminal count
    logic                hold_done; // Reset stretch finished

    assign div_tc    = (div_cnt == CLKEN_CW'(CLKEN_DIV - 1));
    assign hold_done = (hold_cnt == HOLD_CW'(RESET_HOLD));

    // Free-running modulo counter
    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else if (div_tc)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // Stands in for the power-on reset stretcher
    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
            hold_cnt <= '0;
        else if (div_tc && !hold_done)
            hold_cnt <= hold_cnt + 1'b1;    // Stops once saturated
    end

    // First RESET_HOLD terminal counts swallowed
    assign cpu_clken = div_tc && hold_done;

endmodule

/* hw/monitor_rom.hex */
// Monitor ROM image, hex bytes in address order, @ sets the page offset
// Offsets not listed keep the EA fill
@00
D8 58 A0 7F
8C 12 D0 A9
A7 8D 11 D0
8D 13 D0 C9
@FC
00 FF

/* hw/monitor_rom.sv */
`timescale 1ns/10ps

module monitor_rom (
    input  logic                          clk25,
    input  logic                          cpu_clken,  // Strobe
    input  logic [apple1_pkg::ROM_AW-1:0] addr,
    output logic [7:0]                    rdata
);
    import apple1_pkg::*;

    logic [7:0] mem [0:(2**ROM_AW)-1];  // Monitor page 0xFF00

    // Unused bytes read as NOP; image file may place bytes with @ lines
    // Reset vector at 0xFC/0xFD comes from the image
    initial
    begin
        for (int i = 0; i < 2**ROM_AW; i++)
            mem[i] = 8'hEA;
        $readmemh("monitor_rom.hex", mem);
    end

    always_ff @(posedge clk25)
    begin
        if (cpu_clken)
            rdata <= mem[addr];
    end

endmodule

/* hw/ram_8k.sv */
`timescale 1ns/10ps

module ram_8k (
    input  logic                       clk25,
    input  logic                       cpu_clken,   // Strobe
    input  logic [apple1_pkg::RAM_AW-1:0] addr,
    input  logic                       we,
    input  logic [7:0]                 wdata,
    output logic [7:0]                 rdata
);
    import apple1_pkg::*;

    logic [7:0] mem [0:(2**RAM_AW)-1];  // 8 KiB array

    // Single port, read-before-write
    always_ff @(posedge clk25)
    begin
        if (cpu_clken)
        begin
            if (we)
                mem[addr] <= wdata;
            rdata <= mem[addr];         // Old data on a write cycle
        end
    end

endmodule

/* hw/terminal_io.sv */
`timescale 1ns/10ps

module terminal_io #(
    parameter int clks_per_bit = 217
) (
    input  logic                  clk25,
    input  logic                  rst,
    input  logic                  sel,       // Strobed access
    input  logic                  we,
    input  apple1_pkg::term_reg_e reg_addr,
    input  logic [7:0]            wdata,
    output logic [7:0]            rdata,
    input  logic                  uart_rx,
    output logic                  uart_tx,
    output logic                  uart_cts
);
    import apple1_pkg::*;

    logic       tx_start;
    logic       tx_busy;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic [7:0] kbd_data;   // Last received character
    logic       key_ready;  // KBDCR bit 7
    logic       kbd_read;
    logic [7:0] reg_view;

    ////////////////////////////////////////////////////////////////////////////
    // Serial link

    uart_8n1 #(
        .clks_per_bit(clks_per_bit)
    ) u_uart_8n1 (
        .clk25   (clk25),
        .rst     (rst),
        .tx_start(tx_start),
        .tx_data ({1'b0, wdata[6:0]}),  // 7-bit ASCII, bit 7 sent low
        .tx_busy (tx_busy),
        .uart_tx (uart_tx),
        .uart_rx (uart_rx),
        .rx_valid(rx_valid),
        .rx_data (rx_data)
    );

    // Writes while busy are lost, software polls DSP first
    assign tx_start = sel && we && (reg_addr == TERM_DSP) && !tx_busy;
    assign kbd_read = sel && !we && (reg_addr == TERM_KBD);

    ////////////////////////////////////////////////////////////////////////////
    // Keyboard side

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
            key_ready <= 1'b0;
        else if (rx_valid)
            key_ready <= 1'b1;      // New key wins over a same-cycle read
        else if (kbd_read)
            key_ready <= 1'b0;
    end

    // Overrun just replaces the character
    always_ff @(posedge clk25)
    begin
        if (rx_valid)
            kbd_data <= rx_data;
    end

    assign uart_cts = !key_ready;   // Host holds off until key taken

    ////////////////////////////////////////////////////////////////////////////
    // Register view

    always_comb
    begin
        case (reg_addr)
            TERM_KBD:   reg_view = {1'b1, kbd_data[6:0]};
            TERM_KBDCR: reg_view = {key_ready, 7'b0};
            TERM_DSP:   reg_view = {tx_busy, 7'b0};   // Busy in bit 7
            default:    reg_view = 8'h00;             // DSPCR
        endcase
    end

    always_ff @(posedge clk25)
    begin
        if (sel)
            rdata <= reg_view;      // Held until next terminal access
    end

endmodule

/* hw/uart_8n1.sv */
`timescale 1ns/10ps

module uart_8n1 #(
    parameter int clks_per_bit = 217    // 115200 baud at 25 MHz
) (
    input  logic       clk25,
    input  logic       rst,
    input  logic       tx_start,   // Ignored while busy
    input  logic [7:0] tx_data,
    output logic       tx_busy,
    output logic       uart_tx,
    input  logic       uart_rx,    // Asynchronous
    output logic       rx_valid,   // One-cycle pulse
    output logic [7:0] rx_data
);
    import apple1_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Transmitter

    uart_state_e tx_state;
    logic [15:0] tx_cnt;       // Clocks within current bit
    logic [2:0]  tx_idx;       // Data bit number
    logic [7:0]  tx_shift;
    logic        tx_q;         // Registered line, no glitches
    logic        tx_end;

    assign tx_end  = (tx_cnt == 16'(clks_per_bit - 1));
    assign tx_busy = (tx_state != UART_IDLE);
    assign uart_tx = tx_q;

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            tx_state <= UART_IDLE;
            tx_cnt   <= '0;
            tx_idx   <= '0;
            tx_shift <= '0;
            tx_q     <= 1'b1;       // Idle mark
        end
        else
        begin
            tx_cnt <= tx_end ? '0 : tx_cnt + 16'd1;
            case (tx_state)
                UART_IDLE:
                begin
                    tx_cnt <= '0;
                    if (tx_start)
                    begin
                        tx_shift <= tx_data;
                        tx_q     <= 1'b0;   // Start bit
                        tx_state <= UART_START;
                    end
                end
                UART_START:
                begin
                    if (tx_end)
                    begin
                        tx_idx   <= '0;
                        tx_q     <= tx_shift[0];    // LSB first
                        tx_state <= UART_DATA;
                    end
                end
                UART_DATA:
                begin
                    if (tx_end)
                    begin
                        tx_idx   <= tx_idx + 3'd1;
                        tx_shift <= tx_shift >> 1;
                        if (tx_idx == 3'd7)
                        begin
                            tx_q     <= 1'b1;       // Stop bit
                            tx_state <= UART_STOP;
                        end
                        else
                            tx_q <= tx_shift[1];    // Next bit after shift
                    end
                end
                default:
                begin
                    if (tx_end)
                        tx_state <= UART_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Receiver

    uart_state_e rx_state;
    logic [15:0] rx_cnt;
    logic [2:0]  rx_idx;
    logic [7:0]  rx_shift;
    logic        rx_meta, rx_sync, rx_prev;    // Two-flop sync plus edge flop
    logic        rx_end, rx_half;

    assign rx_end  = (rx_cnt == 16'(clks_per_bit - 1));
    assign rx_half = (rx_cnt == 16'(clks_per_bit / 2 - 1));

    always_ff @(posedge clk25 or posedge rst)
    begin
        if (rst)
        begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
            rx_state <= UART_IDLE;
            rx_cnt   <= '0;
            rx_idx   <= '0;
            rx_shift <= '0;
            rx_valid <= 1'b0;
            rx_data  <= '0;
        end
        else
        begin
            rx_meta  <= uart_rx;
            rx_sync  <= rx_meta;
            rx_prev  <= rx_sync;
            rx_valid <= 1'b0;
            rx_cnt   <= rx_end ? '0 : rx_cnt + 16'd1;
            case (rx_state)
                UART_IDLE:
                begin
                    rx_cnt <= '0;
                    if (rx_prev && !rx_sync)
                        rx_state <= UART_START;     // Falling edge
                end
                UART_START:
                begin
                    if (rx_half)
                    begin
                        rx_cnt   <= '0;             // Now aligned to mid-bit
                        rx_idx   <= '0;
                        rx_state <= rx_sync ? UART_IDLE : UART_DATA;   // Glitch check
                    end
                end
                UART_DATA:
                begin
                    if (rx_end)
                    begin
                        rx_shift <= {rx_sync, rx_shift[7:1]};
                        rx_idx   <= rx_idx + 3'd1;
                        if (rx_idx == 3'd7)
                            rx_state <= UART_STOP;
                    end
                end
                default:
                begin
                    if (rx_end)
                    begin
                        rx_valid <= rx_sync;        // Framing error drops byte
                        rx_data  <= rx_shift;
                        rx_state <= UART_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* verif/apple1_tb.sv */
`timescale 1ns/10ps

module apple1_tb;
    import apple1_pkg::*;

    localparam int BIT_CLKS = 16;   // Serial bit period in clk25 cycles

    // Bus master operations with one table row each
    typedef enum logic [2:0] {
        OP_WRITE,       // Bus write
        OP_READ,        // Bus read, compare rdata
        OP_SEND,        // Character into uart_rx
        OP_CTS,         // Compare uart_cts with exp_val bit 0
        OP_WAIT_TX,     // Wait for a decoded uart_tx byte
        OP_QUIET        // data strobes with no serial output
    } op_kind_e;

    typedef struct packed {
        op_kind_e    kind;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp_val;
    } op_t;

    logic       clk25;
    logic       rst;
    cpu_bus_t   bus;
    logic       uart_rx;
    logic       cpu_clken;
    logic [7:0] rdata;
    logic       uart_tx;
    logic       uart_cts;

    op_t         ops[$];            // Stimulus table
    logic [7:0]  tx_bytes[$];       // Bytes seen on uart_tx
    logic [7:0]  rd_seen;           // rdata just before the last strobe
    logic [31:0] lfsr_state;
    logic [7:0]  ram_model [0:(2**RAM_AW)-1];  // Last byte written per RAM address
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          error_count = 0;

    apple1_core #(
        .clks_per_bit(BIT_CLKS)
    ) u_apple1_core (
        .clk25    (clk25),
        .rst      (rst),
        .bus      (bus),
        .uart_rx  (uart_rx),
        .cpu_clken(cpu_clken),
        .rdata    (rdata),
        .uart_tx  (uart_tx),
        .uart_cts (uart_cts)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clock and run limit

    initial
    begin
        clk25 = 1'b0;
        forever #4 clk25 = ~clk25;  // 8 ns period
    end

    always @(posedge clk25)
    begin
        cycle_count = cycle_count + 1;
        if (timeout_limit > 0 && cycle_count > timeout_limit)
        begin
            $display("Timeout: run still busy after %0d clock cycles", timeout_limit);
            $display("TEST FAILED");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp_val,
                                input string what);
        assert (got === exp_val)
        else
        begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s gave %02h, expected %02h",
                     $time, what, got, exp_val);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond)
        else
        begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s", $time, what);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Galois form with taps 32 31 29 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit with the MSB taken first
    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic cpu_bus_t make_req(input logic [15:0] addr, input logic [7:0] data,
                                          input logic we);
        cpu_bus_t r;
        r.addr  = addr;
        r.wdata = data;
        r.we    = we;
        return r;
    endfunction

    task automatic add_op(input op_kind_e kind, input logic [15:0] addr,
                          input logic [7:0] data, input logic [7:0] exp_val);
        op_t op;
        op.kind    = kind;
        op.addr    = addr;
        op.data    = data;
        op.exp_val = exp_val;
        ops.push_back(op);
    endtask

    // Returns just after a strobe edge with rdata sampled half a cycle before it
    task automatic to_strobe();
        @(negedge clk25);
        while (cpu_clken !== 1'b1)
            @(negedge clk25);
        rd_seen = rdata;
        @(posedge clk25);
    endtask

    // 8N1 frame sent LSB first
    task automatic send_serial(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int b = 0; b < 10; b++)
        begin
            @(posedge clk25);
            uart_rx <= frame[b];
            repeat (BIT_CLKS - 1) @(posedge clk25);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Serial monitor

    initial
    begin
        logic [7:0] byte_v;
        @(negedge rst);
        forever
        begin
            @(negedge uart_tx);
            repeat (BIT_CLKS / 2) @(negedge clk25);  // Middle of start bit
            expect_true(uart_tx === 1'b0, "uart_tx start bit not low at mid-bit");
            for (int b = 0; b < 8; b++)
            begin
                repeat (BIT_CLKS) @(negedge clk25);
                byte_v[b] = uart_tx;
            end
            repeat (BIT_CLKS) @(negedge clk25);
            expect_true(uart_tx === 1'b1, "uart_tx stop bit not high");
            tx_bytes.push_back(byte_v);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table

    task automatic build_table();
        logic [15:0] addr;
        logic [15:0] rnd;
        logic [7:0]  data;
        logic [15:0] ram_addrs[8];
        // RAM at both ends plus scattered LFSR addresses
        for (int j = 0; j < 8; j++)
        begin
            if (j == 0)
                addr = 16'h0000;
            else if (j == 7)
                addr = 16'h1FFF;
            else
                addr = random_bits(RAM_AW);     // Upper bits stay 0
            rnd  = random_bits(8);
            data = rnd[7:0];
            ram_addrs[j] = addr;
            ram_model[addr[RAM_AW-1:0]] = data;
            add_op(OP_WRITE, addr, data, 8'h00);
            add_op(OP_READ, addr, 8'h00, data);
        end
        // Second pass catches writes that landed on the wrong address
        for (int j = 0; j < 8; j++)
            add_op(OP_READ, ram_addrs[j], 8'h00, ram_model[ram_addrs[j][RAM_AW-1:0]]);
        // ROM image bytes and fill
        add_op(OP_READ, ROM_BASE + 16'h00FC, 8'h00, 8'h00);   // Reset vector low
        add_op(OP_READ, ROM_BASE + 16'h00FD, 8'h00, 8'hFF);   // Reset vector high
        add_op(OP_READ, ROM_BASE, 8'h00, 8'hD8);
        add_op(OP_READ, ROM_BASE + 16'h0080, 8'h00, 8'hEA);
        // Holes in the map
        add_op(OP_READ, 16'h2000, 8'h00, UNMAPPED_DATA);
        add_op(OP_READ, TERM_BASE + 16'h0004, 8'h00, UNMAPPED_DATA);
        add_op(OP_READ, 16'hC000, 8'h00, UNMAPPED_DATA);
        add_op(OP_READ, TERM_BASE - 16'h0001, 8'h00, UNMAPPED_DATA);
        // Keyboard path
        add_op(OP_CTS, 16'h0000, 8'h00, 8'h01);
        add_op(OP_SEND, 16'h0000, 8'h4B, 8'h00);
        add_op(OP_READ, {TERM_BASE[15:2], TERM_KBDCR}, 8'h00, 8'h80);
        add_op(OP_CTS, 16'h0000, 8'h00, 8'h00);                // Key held over status read
        add_op(OP_READ, {TERM_BASE[15:2], TERM_KBD}, 8'h00, 8'h4B | 8'h80);
        add_op(OP_READ, {TERM_BASE[15:2], TERM_KBDCR}, 8'h00, 8'h00);
        add_op(OP_CTS, 16'h0000, 8'h00, 8'h01);
        add_op(OP_READ, {TERM_BASE[15:2], TERM_DSPCR}, 8'h00, 8'h00);
        // Display path with a second write landing while busy
        add_op(OP_WRITE, {TERM_BASE[15:2], TERM_DSP}, 8'hC8, 8'h00);
        add_op(OP_READ, {TERM_BASE[15:2], TERM_DSP}, 8'h00, 8'h80);
        add_op(OP_WRITE, {TERM_BASE[15:2], TERM_DSP}, 8'h69, 8'h00);
        add_op(OP_WAIT_TX, 16'h0000, 8'h00, 8'hC8 & 8'h7F);   // Bit 7 goes out low
        add_op(OP_READ, {TERM_BASE[15:2], TERM_DSP}, 8'h00, 8'h00);
        add_op(OP_QUIET, 16'h0000, 8'd12, 8'h00);              // Longer than a frame
    endtask

    task automatic run_op(input op_t op);
        case (op.kind)
            OP_WRITE:
            begin
                to_strobe();
                bus <= make_req(op.addr, op.data, 1'b1);
                to_strobe();                        // Write lands here
                bus <= make_req(16'hC000, 8'h00, 1'b0);
            end
            OP_READ:
            begin
                to_strobe();
                bus <= make_req(op.addr, 8'h00, 1'b0);
                to_strobe();                        // Access strobe
                bus <= make_req(16'hC000, 8'h00, 1'b0);
                to_strobe();
                compare_byte(rd_seen, op.exp_val, $sformatf("read of %04h", op.addr));
            end
            OP_SEND:
            begin
                send_serial(op.data);
                while (uart_cts !== 1'b0)           // Key-ready handshake
                    @(negedge clk25);
            end
            OP_CTS:
            begin
                @(negedge clk25);
                expect_true(uart_cts === op.exp_val[0],
                            $sformatf("uart_cts is %b, expected %b", uart_cts, op.exp_val[0]));
            end
            OP_WAIT_TX:
            begin
                while (tx_bytes.size() == 0)
                    @(negedge clk25);
                compare_byte(tx_bytes.pop_front(), op.exp_val, "uart_tx character");
            end
            default:
            begin
                repeat (op.data) to_strobe();
                expect_true(tx_bytes.size() == 0, "extra character on uart_tx");
                expect_true(uart_tx === 1'b1, "uart_tx not idle");
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reset and enable timing

    task automatic verify_enable_timing();
        int low_cycles;
        int gap;
        @(negedge clk25);
        compare_byte(rdata, UNMAPPED_DATA, "rdata after reset");
        expect_true(uart_tx === 1'b1, "uart_tx not idle after reset");
        expect_true(uart_cts === 1'b1, "uart_cts not high after reset");
        low_cycles = 0;
        while (cpu_clken !== 1'b1)
        begin
            low_cycles++;
            @(negedge clk25);
        end
        // Hold covers RESET_HOLD periods and the first pulse comes within one more
        expect_true(low_cycles >= RESET_HOLD * CLKEN_DIV,
                    $sformatf("first cpu_clken after only %0d cycles", low_cycles));
        expect_true(low_cycles <= (RESET_HOLD + 1) * CLKEN_DIV,
                    $sformatf("first cpu_clken late, %0d cycles", low_cycles));
        repeat (3)
        begin
            gap = 0;
            @(negedge clk25);
            gap++;
            while (cpu_clken !== 1'b1)
            begin
                @(negedge clk25);
                gap++;
            end
            expect_true(gap == CLKEN_DIV, $sformatf("cpu_clken pulses %0d cycles apart", gap));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial
    begin
        rst        = 1'b1;
        uart_rx    = 1'b1;                      // Line idle
        bus        = make_req(16'hC000, 8'h00, 1'b0);
        lfsr_state = 32'h8d86;
        build_table();
        timeout_limit = ops.size() * CLKEN_DIV * 200;
        repeat (2) @(posedge clk25);
        rst <= 1'b0;
        verify_enable_timing();
        for (int i = 0; i < ops.size(); i++)
            run_op(ops[i]);
        if (error_count == 0)
        begin
            $display("TEST OK");
            $finish;
        end
        else
        begin
            $display("TEST FAILED");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

endmodule

/* vlog.f */
hw/apple1_pkg.sv
hw/cpu_clock_reset.sv
hw/bus_decoder.sv
hw/ram_8k.sv
hw/monitor_rom.sv
hw/uart_8n1.sv
hw/terminal_io.sv
hw/apple1_core.sv
verif/apple1_tb.sv
